// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // Major opcodes handled by a lane
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [6:0] F7_BASE    = 7'h00;  // Plain op
    localparam logic [6:0] F7_ALT     = 7'h20;  // SUB, SRA, SRAI
    localparam logic [6:0] F7_MULDIV  = 7'h01;  // M extension

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } exu_inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;  // Upper 7 bits act as funct7 for shifts
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } exu_inst_i_t;

    typedef union packed {
        exu_inst_r_t r;
        exu_inst_i_t i;
    } exu_inst_u;

    typedef struct packed {
        exu_inst_u   inst;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;       // Already sign extended
    } exu_op_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        reg_we;
        logic        inst_invalid;
        logic [31:0] result;
        logic [31:0] next_pc;
    } exu_res_t;

endpackage

`default_nettype wire

// ==== rtl/issue_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_dispatch #(
    parameter int LANES = 4
) (
    input  wire logic             clock,
    input  wire logic             rst,

    input  wire logic             in_valid,
    output logic                  in_ready,
    input  wire exu_pkg::exu_op_t in_op,

    output logic [LANES-1:0]      lane_valid,
    input  wire logic [LANES-1:0] lane_ready,
    output exu_pkg::exu_op_t      lane_op
);

    localparam int PW = $clog2(LANES);

    logic [PW-1:0] ptr;
    logic          xfer;

    // Only the lane under the pointer sees valid
    always_comb begin
        lane_valid      = '0;
        lane_valid[ptr] = in_valid;
    end

    assign in_ready = lane_ready[ptr];
    assign lane_op  = in_op;  // Shared bus, valid picks the lane
    assign xfer     = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            ptr <= '0;
        end else if (xfer) begin
            if (ptr == PW'(LANES - 1)) begin
                ptr <= '0;  // Wrap
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exu_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_lane (
    input  wire logic             clock,
    input  wire logic             rst,

    input  wire logic             op_valid,
    output logic                  op_ready,
    input  wire exu_pkg::exu_op_t op,

    output logic                  res_valid,
    input  wire logic             res_take,
    output exu_pkg::exu_res_t     res
);

    logic              full;
    logic              accept;
    exu_pkg::exu_res_t res_q;
    exu_pkg::exu_res_t res_d;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [6:0]  sh_funct7;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] sum;
    logic [31:0] sra_out;
    logic [31:0] pc_plus4;
    logic [31:0] alu_out;
    logic [31:0] next_pc;
    logic [63:0] mul_full;
    logic [4:0]  shamt;
    logic        lt_s;
    logic        lt_u;
    logic        div_ovf;
    logic        branch_taken;
    logic        inst_invalid;

    assign opcode    = op.inst.r.opcode;
    assign funct3    = op.inst.r.funct3;
    assign funct7    = op.inst.r.funct7;
    assign sh_funct7 = op.inst.i.imm12[11:5];

    always_comb begin
        case (opcode)
            exu_pkg::OPC_AUIPC, exu_pkg::OPC_JAL: alu_a = op.pc;
            exu_pkg::OPC_LUI:                     alu_a = '0;
            default:                              alu_a = op.rs1_data;
        endcase
    end

    assign alu_b = (opcode == exu_pkg::OPC_OP || opcode == exu_pkg::OPC_BRANCH) ?
                   op.rs2_data : op.imm;

    assign sum      = alu_a + alu_b;  // Also JAL target and JALR base
    assign shamt    = alu_b[4:0];
    assign sra_out  = $signed(alu_a) >>> shamt;
    assign mul_full = $signed(alu_a) * $signed(alu_b);
    assign lt_s     = $signed(alu_a) < $signed(alu_b);
    assign lt_u     = alu_a < alu_b;
    assign div_ovf  = (alu_a == 32'h8000_0000) && (alu_b == 32'hffff_ffff);
    assign pc_plus4 = op.pc + 32'd4;

    always_comb begin
        alu_out      = '0;
        inst_invalid = 1'b0;
        case (opcode)
            exu_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    {exu_pkg::F7_BASE, 3'b000}: alu_out = sum;
                    {exu_pkg::F7_ALT, 3'b000}:  alu_out = alu_a - alu_b;
                    {exu_pkg::F7_BASE, 3'b001}: alu_out = alu_a << shamt;
                    {exu_pkg::F7_BASE, 3'b010}: alu_out = {31'd0, lt_s};
                    {exu_pkg::F7_BASE, 3'b011}: alu_out = {31'd0, lt_u};
                    {exu_pkg::F7_BASE, 3'b100}: alu_out = alu_a ^ alu_b;
                    {exu_pkg::F7_BASE, 3'b101}: alu_out = alu_a >> shamt;
                    {exu_pkg::F7_ALT, 3'b101}:  alu_out = sra_out;
                    {exu_pkg::F7_BASE, 3'b110}: alu_out = alu_a | alu_b;
                    {exu_pkg::F7_BASE, 3'b111}: alu_out = alu_a & alu_b;
                    {exu_pkg::F7_MULDIV, 3'b000}: alu_out = mul_full[31:0];   // MUL
                    {exu_pkg::F7_MULDIV, 3'b001}: alu_out = mul_full[63:32];  // MULH
                    {exu_pkg::F7_MULDIV, 3'b100}: begin  // DIV
                        if (alu_b == '0) begin
                            alu_out = '1;
                        end else if (div_ovf) begin
                            alu_out = 32'h8000_0000;
                        end else begin
                            alu_out = $signed(alu_a) / $signed(alu_b);
                        end
                    end
                    {exu_pkg::F7_MULDIV, 3'b101}: begin  // DIVU
                        alu_out = (alu_b == '0) ? '1 : alu_a / alu_b;
                    end
                    {exu_pkg::F7_MULDIV, 3'b110}: begin  // REM
                        if (alu_b == '0) begin
                            alu_out = alu_a;
                        end else if (div_ovf) begin
                            alu_out = '0;
                        end else begin
                            alu_out = $signed(alu_a) % $signed(alu_b);
                        end
                    end
                    {exu_pkg::F7_MULDIV, 3'b111}: begin  // REMU
                        alu_out = (alu_b == '0) ? alu_a : alu_a % alu_b;
                    end
                    default: inst_invalid = 1'b1;
                endcase
            end
            exu_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: alu_out = sum;
                    3'b010: alu_out = {31'd0, lt_s};
                    3'b011: alu_out = {31'd0, lt_u};
                    3'b100: alu_out = alu_a ^ alu_b;
                    3'b110: alu_out = alu_a | alu_b;
                    3'b111: alu_out = alu_a & alu_b;
                    3'b001: begin
                        if (sh_funct7 == exu_pkg::F7_BASE) begin
                            alu_out = alu_a << shamt;
                        end else begin
                            inst_invalid = 1'b1;
                        end
                    end
                    default: begin  // SRLI or SRAI
                        if (sh_funct7 == exu_pkg::F7_BASE) begin
                            alu_out = alu_a >> shamt;
                        end else if (sh_funct7 == exu_pkg::F7_ALT) begin
                            alu_out = sra_out;
                        end else begin
                            inst_invalid = 1'b1;
                        end
                    end
                endcase
            end
            exu_pkg::OPC_LUI,
            exu_pkg::OPC_AUIPC,
            exu_pkg::OPC_LOAD,
            exu_pkg::OPC_STORE:  alu_out = sum;  // Sum of the selected operands
            exu_pkg::OPC_JAL,
            exu_pkg::OPC_JALR:   alu_out = pc_plus4;  // Link value
            exu_pkg::OPC_BRANCH: alu_out = '0;
            default:             inst_invalid = 1'b1;
        endcase
    end

    // Operands are rs1 and rs2 for branches
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (alu_a == alu_b);
            3'b001:  branch_taken = (alu_a != alu_b);
            3'b100:  branch_taken = lt_s;
            3'b101:  branch_taken = !lt_s;
            3'b110:  branch_taken = lt_u;
            3'b111:  branch_taken = !lt_u;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (opcode == exu_pkg::OPC_JAL) begin
            next_pc = sum;
        end else if (opcode == exu_pkg::OPC_JALR) begin
            next_pc = {sum[31:1], 1'b0};
        end else if (opcode == exu_pkg::OPC_BRANCH && branch_taken) begin
            next_pc = op.pc + op.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign res_d.rd           = op.inst.r.rd;
    assign res_d.reg_we       = !inst_invalid && opcode != exu_pkg::OPC_BRANCH &&
                                opcode != exu_pkg::OPC_STORE;
    assign res_d.inst_invalid = inst_invalid;
    assign res_d.result       = alu_out;
    assign res_d.next_pc      = next_pc;

    assign op_ready  = !full || res_take;  // Refill in the cycle it drains
    assign accept    = op_valid && op_ready;
    assign res_valid = full;
    assign res       = res_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (res_take) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            res_q <= res_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/retire_collect.sv ====
`timescale 1ns/10ps
`default_nettype none

module retire_collect #(
    parameter int LANES = 4
) (
    input  wire logic                          clock,
    input  wire logic                          rst,

    input  wire logic [LANES-1:0]              res_valid,
    input  wire exu_pkg::exu_res_t [LANES-1:0] res,
    output logic [LANES-1:0]                   res_take,

    output logic                               out_valid,
    input  wire logic                          out_ready,
    output exu_pkg::exu_res_t                  out_res
);

    localparam int PW = $clog2(LANES);

    logic [PW-1:0] ptr;
    logic          xfer;

    assign out_valid = res_valid[ptr];
    assign out_res   = res[ptr];
    assign xfer      = out_valid && out_ready;

    // Head lane only, so results leave in issue order
    always_comb begin
        res_take      = '0;
        res_take[ptr] = out_ready;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ptr <= '0;
        end else if (xfer) begin
            if (ptr == PW'(LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exu_cluster.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_cluster #(
    parameter int LANES = 4
) (
    input  wire logic              clock,
    input  wire logic              rst,

    input  wire logic              in_valid,
    output logic                   in_ready,
    input  wire exu_pkg::exu_op_t  in_op,

    output logic                   out_valid,
    input  wire logic              out_ready,
    output exu_pkg::exu_res_t      out_res
);

    logic [LANES-1:0]              lane_valid;
    logic [LANES-1:0]              lane_ready;
    exu_pkg::exu_op_t              lane_op;
    logic [LANES-1:0]              res_valid;
    exu_pkg::exu_res_t [LANES-1:0] res;
    logic [LANES-1:0]              res_take;

    issue_dispatch #(
        .LANES(LANES)
    ) i_issue_dispatch (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .lane_valid(lane_valid),
        .lane_ready(lane_ready),
        .lane_op   (lane_op)
    );

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        exu_lane i_exu_lane (
            .clock    (clock),
            .rst      (rst),
            .op_valid (lane_valid[k]),
            .op_ready (lane_ready[k]),
            .op       (lane_op),
            .res_valid(res_valid[k]),
            .res_take (res_take[k]),
            .res      (res[k])
        );
    end

    retire_collect #(
        .LANES(LANES)
    ) i_retire_collect (
        .clock    (clock),
        .rst      (rst),
        .res_valid(res_valid),
        .res      (res),
        .res_take (res_take),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_res  (out_res)
    );

endmodule

`default_nettype wire

// ==== bench/exu_cluster_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_cluster_checker #(
    parameter int LANES = 4
) (
    input wire logic              clock,
    input wire logic              rst,
    input wire logic              in_ready,
    input wire logic              out_valid,
    input wire logic              out_ready,
    input wire exu_pkg::exu_res_t out_res,
    input wire logic [LANES-1:0]  res_valid
);

    int fail_count = 0;

    // Stalled result keeps its place and value
    a_out_hold: assert property (@(posedge clock) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_res))
        else begin
            $error("output result moved while out_ready was low");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge clock) rst |=> !out_valid)
        else begin
            $error("out_valid high right after reset");
            fail_count++;
        end

    a_empty_ready: assert property (@(posedge clock) disable iff (rst)
        res_valid == '0 |-> in_ready)
        else begin
            $error("in_ready low with every lane empty");
            fail_count++;
        end

endmodule

bind exu_cluster exu_cluster_checker #(
    .LANES(LANES)
) i_exu_cluster_checker (
    .clock    (clock),
    .rst      (rst),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_res  (out_res),
    .res_valid(res_valid)
);

`default_nettype wire

// ==== bench/exu_cluster_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_cluster_tb;

    logic              clock;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    exu_pkg::exu_op_t  in_op;
    logic              out_valid;
    logic              out_ready;
    exu_pkg::exu_res_t out_res;

    exu_pkg::exu_res_t exp_q[$];  // Expected results in issue order
    logic [31:0]       lfsr;
    string             test_name;
    int                errors;
    int                test_errors;
    int                checks;
    int                issued;
    int                cycles;

    exu_cluster #(
        .LANES(4)
    ) i_exu_cluster (
        .clock    (clock),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_op    (in_op),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_res  (out_res)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic exu_pkg::exu_op_t mk_op(input logic [6:0] opc, input logic [6:0] f7,
            input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
            input logic [31:0] imm, input logic [31:0] pc);
        exu_pkg::exu_op_t op;
        op                = '0;
        op.inst.r.opcode  = opc;
        op.inst.r.funct3  = f3;
        op.inst.r.funct7  = f7;
        op.inst.r.rd      = {2'b01, f3};
        op.inst.r.rs1     = 5'd1;
        op.inst.r.rs2     = 5'd2;
        if (opc == exu_pkg::OPC_OP_IMM || opc == exu_pkg::OPC_LOAD ||
            opc == exu_pkg::OPC_JALR) begin
            op.inst.i.imm12 = imm[11:0];  // I-type word carries the immediate
        end
        op.pc       = pc;
        op.rs1_data = a;
        op.rs2_data = b;
        op.imm      = imm;
        return op;
    endfunction

    // Expected result straight from the RV32IM instruction semantics
    function automatic exu_pkg::exu_res_t model(input exu_pkg::exu_op_t op);
        exu_pkg::exu_res_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [31:0] v;
        logic [63:0] prod;
        logic [4:0]  sh;
        logic        ok;
        logic        we;
        logic        taken;
        a     = op.rs1_data;
        b     = op.rs2_data;
        im    = op.imm;
        sh    = (op.inst.r.opcode == exu_pkg::OPC_OP) ? b[4:0] : im[4:0];
        prod  = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        v     = '0;
        ok    = 1'b1;
        we    = 1'b1;
        taken = 1'b0;
        r.next_pc = op.pc + 32'd4;
        case (op.inst.r.opcode)
            exu_pkg::OPC_OP: begin
                case ({op.inst.r.funct7, op.inst.r.funct3})
                    {7'h00, 3'd0}: v = a + b;
                    {7'h20, 3'd0}: v = a - b;
                    {7'h00, 3'd1}: v = a << sh;
                    {7'h00, 3'd2}: v = 32'($signed(a) < $signed(b));
                    {7'h00, 3'd3}: v = 32'(a < b);
                    {7'h00, 3'd4}: v = a ^ b;
                    {7'h00, 3'd5}: v = a >> sh;
                    {7'h20, 3'd5}: v = a[31] ? ~(~a >> sh) : a >> sh;
                    {7'h00, 3'd6}: v = a | b;
                    {7'h00, 3'd7}: v = a & b;
                    {7'h01, 3'd0}: v = prod[31:0];
                    {7'h01, 3'd1}: v = prod[63:32];
                    {7'h01, 3'd4}: begin
                        if (b == 32'd0) v = '1;
                        else if (a == 32'h8000_0000 && b == '1) v = a;
                        else v = $signed(a) / $signed(b);
                    end
                    {7'h01, 3'd5}: v = (b == 32'd0) ? '1 : a / b;
                    {7'h01, 3'd6}: begin
                        if (b == 32'd0) v = a;
                        else if (a == 32'h8000_0000 && b == '1) v = '0;
                        else v = $signed(a) % $signed(b);
                    end
                    {7'h01, 3'd7}: v = (b == 32'd0) ? a : a % b;
                    default: ok = 1'b0;
                endcase
            end
            exu_pkg::OPC_OP_IMM: begin
                case ({op.inst.i.imm12[11:5], op.inst.r.funct3})
                    {7'h00, 3'd1}: v = a << sh;
                    {7'h00, 3'd5}: v = a >> sh;
                    {7'h20, 3'd5}: v = a[31] ? ~(~a >> sh) : a >> sh;
                    default: begin
                        case (op.inst.r.funct3)
                            3'd0:    v = a + im;
                            3'd2:    v = 32'($signed(a) < $signed(im));
                            3'd3:    v = 32'(a < im);
                            3'd4:    v = a ^ im;
                            3'd6:    v = a | im;
                            3'd7:    v = a & im;
                            default: ok = 1'b0;  // Shift with a bad upper field
                        endcase
                    end
                endcase
            end
            exu_pkg::OPC_LUI:   v = im;
            exu_pkg::OPC_AUIPC: v = op.pc + im;
            exu_pkg::OPC_LOAD:  v = a + im;
            exu_pkg::OPC_STORE: begin
                v  = a + im;
                we = 1'b0;
            end
            exu_pkg::OPC_JAL: begin
                v         = op.pc + 32'd4;
                r.next_pc = op.pc + im;
            end
            exu_pkg::OPC_JALR: begin
                v         = op.pc + 32'd4;
                r.next_pc = (a + im) & ~32'd1;
            end
            exu_pkg::OPC_BRANCH: begin
                we = 1'b0;
                case (op.inst.r.funct3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    3'd7:    taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) r.next_pc = op.pc + im;
            end
            default: ok = 1'b0;
        endcase
        r.rd           = op.inst.r.rd;
        r.reg_we       = ok && we;
        r.inst_invalid = !ok;
        r.result       = ok ? v : 32'd0;
        if (!ok) r.next_pc = op.pc + 32'd4;
        return r;
    endfunction

    // Scoreboard on every output transfer
    always @(posedge clock) begin
        if (!rst && out_valid && out_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("%s: a result came out with no operation pending", test_name);
                errors++;
            end else begin
                if (out_res !== exp_q[0]) begin
                    $display("error %s: expected %h actual %h", test_name, exp_q[0], out_res);
                    errors++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > 20 * issued + 200) begin
            $display("timeout after %0d cycles, %0d results missing", cycles, exp_q.size());
            $display("Verification failed");
            $finish;
        end
    end

    task automatic send(input exu_pkg::exu_op_t op);
        @(negedge clock);
        in_valid = 1'b1;
        in_op    = op;
        exp_q.push_back(model(op));
        issued++;
        @(posedge clock);
        while (!in_ready) @(posedge clock);
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) @(negedge clock);
        $display("test %s finished with %0d errors", test_name, errors - test_errors);
    endtask

    task automatic reset_state();
        start_test("reset");
        @(negedge clock);
        checks += 2;
        if (out_valid !== 1'b0) begin
            $display("error reset: out_valid expected 0 actual %b", out_valid);
            errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("error reset: in_ready expected 1 actual %b", in_ready);
            errors++;
        end
        finish_test();
    endtask

    task automatic rv32i_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        int          f;
        start_test("rv32i");
        for (f = 0; f < 8; f++) begin
            a = take_bits(32);
            b = take_bits(32);
            send(mk_op(exu_pkg::OPC_OP, 7'h00, 3'(f), a, b, 32'd0, 32'h100));
            imm = (f == 1 || f == 5) ? take_bits(5) : sext12(12'(take_bits(12)));
            send(mk_op(exu_pkg::OPC_OP_IMM, 7'h00, 3'(f), a, b, imm, 32'h100));
        end
        a = take_bits(32) | 32'h8000_0000;  // Negative operand for SRA and SRAI
        b = take_bits(5);
        send(mk_op(exu_pkg::OPC_OP, 7'h20, 3'd0, a, b, 32'd0, 32'h100));
        send(mk_op(exu_pkg::OPC_OP, 7'h20, 3'd5, a, b, 32'd0, 32'h100));
        send(mk_op(exu_pkg::OPC_OP_IMM, 7'h00, 3'd5, a, b, 32'h400 | b, 32'h100));
        finish_test();
    endtask

    task automatic muldiv_ops();
        logic [31:0] a;
        logic [31:0] b;
        int          f;
        start_test("muldiv");
        for (f = 0; f < 8; f++) begin
            a = take_bits(32);
            b = take_bits(32);
            send(mk_op(exu_pkg::OPC_OP, 7'h01, 3'(f), a, b, 32'd0, 32'h200));
            if (f >= 4) begin
                send(mk_op(exu_pkg::OPC_OP, 7'h01, 3'(f), a, 32'd0, 32'd0, 32'h200));
                send(mk_op(exu_pkg::OPC_OP, 7'h01, 3'(f), 32'h8000_0000, 32'hffff_ffff,
                           32'd0, 32'h200));
            end
        end
        finish_test();
    endtask

    task automatic control_flow();
        logic [31:0] pa [3];
        logic [31:0] pb [3];
        logic [31:0] pc;
        logic [31:0] imm;
        int          f;
        int          p;
        start_test("control");
        pa[0] = take_bits(32);
        pb[0] = pa[0];
        pa[1] = 32'hffff_fff0;  // Signed less, unsigned greater
        pb[1] = 32'h0000_0010;
        pa[2] = 32'h0000_0010;
        pb[2] = 32'hffff_fff0;
        for (f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            for (p = 0; p < 3; p++) begin
                pc  = take_bits(30) << 2;
                imm = sext12(12'(take_bits(12))) << 1;
                send(mk_op(exu_pkg::OPC_BRANCH, 7'h00, 3'(f), pa[p], pb[p], imm, pc));
            end
        end
        pc  = take_bits(30) << 2;
        imm = sext12(12'(take_bits(12))) << 2;
        send(mk_op(exu_pkg::OPC_JAL, 7'h00, 3'd0, 32'd0, 32'd0, imm, pc));
        send(mk_op(exu_pkg::OPC_JALR, 7'h00, 3'd0, take_bits(32) | 32'd1, 32'd0, 32'h10, pc));
        finish_test();
    endtask

    task automatic misc_ops();
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] pc;
        start_test("misc");
        a   = take_bits(32);
        imm = sext12(12'(take_bits(12)));
        pc  = take_bits(30) << 2;
        send(mk_op(exu_pkg::OPC_LUI, 7'h00, 3'd0, a, 32'd0, 32'h1234_5000, pc));
        send(mk_op(exu_pkg::OPC_AUIPC, 7'h00, 3'd0, a, 32'd0, 32'hfff0_1000, pc));
        send(mk_op(exu_pkg::OPC_LOAD, 7'h00, 3'd2, a, 32'd0, imm, pc));
        send(mk_op(exu_pkg::OPC_STORE, 7'h00, 3'd2, a, 32'h5a5a_0101, imm, pc));
        send(mk_op(7'b1111111, 7'h00, 3'd0, a, 32'd0, imm, pc));  // Unknown opcode
        send(mk_op(exu_pkg::OPC_OP, 7'h7f, 3'd0, a, 32'd1, 32'd0, pc));
        finish_test();
    endtask

    function automatic exu_pkg::exu_op_t rand_op();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [1:0]  sel;
        a   = take_bits(32);
        b   = take_bits(32);
        f3  = 3'(take_bits(3));
        sel = 2'(take_bits(2));
        imm = take_bits(5) | (a[0] ? 32'h400 : 32'h0);
        case (sel)
            2'd0:    return mk_op(exu_pkg::OPC_OP, 7'h00, f3, a, b, 32'd0, 32'h300);
            2'd1:    return mk_op(exu_pkg::OPC_OP, 7'h01, f3, a, b, 32'd0, 32'h300);
            2'd2:    return mk_op(exu_pkg::OPC_OP_IMM, 7'h00, f3, a, b, imm, 32'h300);
            default: return mk_op(exu_pkg::OPC_BRANCH, 7'h00, f3, a, b, 32'h40, 32'h300);
        endcase
    endfunction

    task automatic random_stream();
        exu_pkg::exu_op_t op;
        int               sent;
        start_test("stream");
        sent = 0;
        op   = rand_op();
        while (sent < 40) begin
            @(negedge clock);
            out_ready = 1'(take_bits(1));
            in_valid  = 1'b1;
            in_op     = op;
            @(posedge clock);
            if (in_ready) begin
                exp_q.push_back(model(op));
                sent++;
                issued++;
                op = rand_op();
            end
        end
        @(negedge clock);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        finish_test();
    endtask

    initial begin
        lfsr        = 32'h34ed_f736;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        issued      = 0;
        cycles      = 0;
        test_name   = "startup";
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_op       = '0;
        out_ready   = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        reset_state();
        rv32i_ops();
        muldiv_ops();
        control_flow();
        misc_ops();
        random_stream();
        errors += i_exu_cluster.i_exu_cluster_checker.fail_count;
        $display("%0d operations, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== exu_cluster.f ====
rtl/exu_pkg.sv
rtl/issue_dispatch.sv
rtl/exu_lane.sv
rtl/retire_collect.sv
rtl/exu_cluster.sv
bench/exu_cluster_checker.sv
bench/exu_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: exu_cluster

sources:
  - rtl/exu_pkg.sv
  - rtl/issue_dispatch.sv
  - rtl/exu_lane.sv
  - rtl/retire_collect.sv
  - rtl/exu_cluster.sv
  - target: test
    files:
      - bench/exu_cluster_checker.sv
      - bench/exu_cluster_tb.sv
